// ==== Bender.yml ====
package:
  name: sprite_subsystem

sources:
  # Shared package first, then the RTL bottom up
  - common/sprite_pkg.sv
  - source/dpram.sv
  - sprite_line_buffer/sprite_line_buffer.sv
  - sprite_renderer/sprite_renderer.sv
  - source/line_composer.sv
  - source/sprite_subsystem.sv

  # Simulation only
  - target: test
    files:
      - test/tb_sprite_subsystem.sv

// ==== build.f ====
common/sprite_pkg.sv
source/dpram.sv
sprite_line_buffer/sprite_line_buffer.sv
sprite_renderer/sprite_renderer.sv
source/line_composer.sv
source/sprite_subsystem.sv
test/tb_sprite_subsystem.sv

// ==== common/sprite_pkg.sv ====
// Shared line geometry, pixel and sprite attribute definitions, imported by every sprite layer block
package sprite_pkg;

    ////////////////////////////////////////
    // Line geometry
    ////////////////////////////////////////

    localparam int line_width    = 640;
    localparam int line_idx_bits = 10;

    // Each buffer is split into banks on the low index bits
    localparam int bank_count = 4;
    localparam int bank_bits  = $clog2(bank_count);
    localparam int word_bits  = line_idx_bits - bank_bits;

    // One erase cycle clears the same word in every bank
    localparam int erase_words = line_width / bank_count;

    ////////////////////////////////////////
    // Sprite table
    ////////////////////////////////////////

    localparam int sprite_count    = 8;
    localparam int sprite_idx_bits = 3;

    // Zero is the transparent value
    typedef logic [15:0] pixel_t;

    // Horizontal run of a single colour
    typedef struct packed {
        logic                     enable;
        logic [line_idx_bits-1:0] x;
        logic [5:0]               width;    // zero draws nothing
        pixel_t                   color;
    } sprite_attr_t;

endpackage

// ==== source/dpram.sv ====
// Single-clock simple dual-port RAM with registered read, shared by line buffer banks and sprite table
module dpram #(
    parameter int  addr_width = 8,
    parameter type data_t     = logic [15:0]
) (
    input  logic                  clk,
    input  logic [addr_width-1:0] wr_addr,
    input  data_t                 wr_data,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] rd_addr,
    output data_t                 rd_data
);

    data_t mem [2**addr_width];

    // Block RAM powers up cleared
    initial begin
        for (int i = 0; i < 2**addr_width; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read of the old word when the same address is written
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== source/line_composer.sv ====
// Streams the display buffer out as a valid/ready pixel stream, then triggers its erase
module line_composer
    import sprite_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     compose_start,
    output logic [line_idx_bits-1:0] composer_rd_idx,
    input  pixel_t                   composer_rd_data,
    output logic                     composer_erase_start,
    input  logic                     erase_busy,
    output pixel_t                   pixel_data,
    output logic                     pixel_valid,
    input  logic                     pixel_ready,
    output logic                     composer_busy
);

    logic                     reading;
    logic [line_idx_bits-1:0] rd_idx;
    logic                     rd_issue;
    logic                     rd_inflight;
    logic                     pop;
    logic [1:0]               q_count;
    logic [1:0]               q_level;
    logic                     q_wr_ptr;
    logic                     q_rd_ptr;
    pixel_t                   q_mem [2];

    assign pop = pixel_valid && pixel_ready;

    // Queue slots taken next cycle, counting the read in flight
    assign q_level  = q_count + 2'(rd_inflight) - 2'(pop);
    assign rd_issue = reading && (q_level < 2'd2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reading              <= 1'b0;
            rd_idx               <= '0;
            rd_inflight          <= 1'b0;
            q_count              <= '0;
            q_wr_ptr             <= 1'b0;
            q_rd_ptr             <= 1'b0;
            composer_erase_start <= 1'b0;
        end else begin
            rd_inflight          <= rd_issue;
            composer_erase_start <= 1'b0;
            q_count              <= q_count + 2'(rd_inflight) - 2'(pop);
            if (rd_inflight) begin
                q_wr_ptr <= ~q_wr_ptr;
            end
            if (pop) begin
                q_rd_ptr <= ~q_rd_ptr;
            end

            if (compose_start) begin
                reading <= 1'b1;
                rd_idx  <= '0;
            end else if (rd_issue) begin
                // Last read out, buffer can be cleared behind it
                if (rd_idx == line_idx_bits'(line_width - 1)) begin
                    reading              <= 1'b0;
                    composer_erase_start <= 1'b1;
                end
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_inflight) begin
            q_mem[q_wr_ptr] <= composer_rd_data;
        end
    end

    assign composer_rd_idx = rd_idx;
    assign pixel_data      = q_mem[q_rd_ptr];
    assign pixel_valid     = (q_count != '0);

    // Held until the stream drains and the erase has finished
    assign composer_busy = compose_start || reading || rd_inflight || pixel_valid ||
                           composer_erase_start || erase_busy;

endmodule

// ==== source/sprite_subsystem.sv ====
// Top of the sprite layer; accepts line starts, swaps the buffers and connects the three blocks
module sprite_subsystem
    import sprite_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       line_start,
    input  logic                       sprite_wr_en,
    input  logic [sprite_idx_bits-1:0] sprite_wr_idx,
    input  sprite_attr_t               sprite_wr_attr,
    output pixel_t                     pixel_data,
    output logic                       pixel_valid,
    input  logic                       pixel_ready,
    output logic                       busy
);

    logic                     line_accept;
    logic                     start_pulse;
    logic                     active_render_buffer;
    logic                     renderer_busy;
    logic                     composer_busy;
    logic [line_idx_bits-1:0] renderer_rd_idx;
    pixel_t                   renderer_rd_data;
    logic [line_idx_bits-1:0] renderer_wr_idx;
    pixel_t                   renderer_wr_data;
    logic                     renderer_wr_en;
    logic [line_idx_bits-1:0] composer_rd_idx;
    pixel_t                   composer_rd_data;
    logic                     composer_erase_start;
    logic                     erase_busy;

    // Line starts arriving while busy are dropped
    assign line_accept = line_start && !busy;
    assign busy        = renderer_busy || composer_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_render_buffer <= 1'b0;
            start_pulse          <= 1'b0;
        end else begin
            start_pulse <= line_accept;
            if (line_accept) begin
                active_render_buffer <= ~active_render_buffer;
            end
        end
    end

    sprite_renderer u_renderer (
        .clk              (clk),
        .rst              (rst),
        .sprite_wr_en     (sprite_wr_en),
        .sprite_wr_idx    (sprite_wr_idx),
        .sprite_wr_attr   (sprite_wr_attr),
        .render_start     (start_pulse),
        .renderer_busy    (renderer_busy),
        .renderer_rd_idx  (renderer_rd_idx),
        .renderer_rd_data (renderer_rd_data),
        .renderer_wr_idx  (renderer_wr_idx),
        .renderer_wr_data (renderer_wr_data),
        .renderer_wr_en   (renderer_wr_en)
    );

    sprite_line_buffer u_line_buffer (
        .clk                  (clk),
        .rst                  (rst),
        .active_render_buffer (active_render_buffer),
        .renderer_rd_idx      (renderer_rd_idx),
        .renderer_rd_data     (renderer_rd_data),
        .renderer_wr_idx      (renderer_wr_idx),
        .renderer_wr_data     (renderer_wr_data),
        .renderer_wr_en       (renderer_wr_en),
        .composer_rd_idx      (composer_rd_idx),
        .composer_rd_data     (composer_rd_data),
        .composer_erase_start (composer_erase_start),
        .erase_busy           (erase_busy)
    );

    line_composer u_composer (
        .clk                  (clk),
        .rst                  (rst),
        .compose_start        (start_pulse),
        .composer_rd_idx      (composer_rd_idx),
        .composer_rd_data     (composer_rd_data),
        .composer_erase_start (composer_erase_start),
        .erase_busy           (erase_busy),
        .pixel_data           (pixel_data),
        .pixel_valid          (pixel_valid),
        .pixel_ready          (pixel_ready),
        .composer_busy        (composer_busy)
    );

endmodule

// ==== sprite_line_buffer/sprite_line_buffer.sv ====
// Double line buffer; one half serves the renderer, the other the composer and its erase sequencer
module sprite_line_buffer
    import sprite_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     active_render_buffer,

    // Renderer side
    input  logic [line_idx_bits-1:0] renderer_rd_idx,
    output pixel_t                   renderer_rd_data,
    input  logic [line_idx_bits-1:0] renderer_wr_idx,
    input  pixel_t                   renderer_wr_data,
    input  logic                     renderer_wr_en,

    // Composer side
    input  logic [line_idx_bits-1:0] composer_rd_idx,
    output pixel_t                   composer_rd_data,
    input  logic                     composer_erase_start,
    output logic                     erase_busy
);

    logic [word_bits-1:0] erase_addr;
    logic                 erase_active;

    // Muxed read data of each buffer
    pixel_t buf_rd_data [2];

    ////////////////////////////////////////
    // Buffer halves
    ////////////////////////////////////////

    for (genvar b = 0; b < 2; b++) begin : g_buf
        logic                     is_render;
        logic [line_idx_bits-1:0] rd_idx;
        logic [word_bits-1:0]     wr_addr;
        pixel_t                   wr_data;
        logic [bank_count-1:0]    wr_en;
        logic [bank_bits-1:0]     rd_sel_q;
        pixel_t                   bank_rd_data [bank_count];

        assign is_render = (active_render_buffer == 1'(b));

        // Renderer owns this half, or else it is being displayed and erased
        assign rd_idx  = is_render ? renderer_rd_idx : composer_rd_idx;
        assign wr_addr = is_render ? renderer_wr_idx[line_idx_bits-1:bank_bits] : erase_addr;
        assign wr_data = is_render ? renderer_wr_data : pixel_t'(0);

        always_comb begin
            for (int k = 0; k < bank_count; k++) begin
                if (is_render) begin
                    wr_en[k] = renderer_wr_en &&
                               (renderer_wr_idx[bank_bits-1:0] == bank_bits'(k));
                end else begin
                    wr_en[k] = erase_active;
                end
            end
        end

        for (genvar k = 0; k < bank_count; k++) begin : g_bank
            dpram #(
                .addr_width (word_bits),
                .data_t     (pixel_t)
            ) u_bank (
                .clk     (clk),
                .wr_addr (wr_addr),
                .wr_data (wr_data),
                .wr_en   (wr_en[k]),
                .rd_addr (rd_idx[line_idx_bits-1:bank_bits]),
                .rd_data (bank_rd_data[k])
            );
        end

        // Bank select follows the registered read by one cycle
        always_ff @(posedge clk) begin
            rd_sel_q <= rd_idx[bank_bits-1:0];
        end

        assign buf_rd_data[b] = bank_rd_data[rd_sel_q];
    end

    assign renderer_rd_data = buf_rd_data[active_render_buffer];
    assign composer_rd_data = buf_rd_data[~active_render_buffer];

    ////////////////////////////////////////
    // Erase sequencer
    ////////////////////////////////////////

    // Clears one word in all banks per cycle, starting the cycle after the request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            erase_active <= 1'b0;
            erase_addr   <= '0;
        end else if (composer_erase_start) begin
            erase_active <= 1'b1;
            erase_addr   <= '0;
        end else if (erase_active) begin
            if (erase_addr == word_bits'(erase_words - 1)) begin
                erase_active <= 1'b0;
            end
            erase_addr <= erase_addr + 1'b1;
        end
    end

    assign erase_busy = erase_active;

endmodule

// ==== sprite_renderer/sprite_renderer.sv ====
// Sprite table and drawing engine; paints enabled sprites into the render buffer on render_start
module sprite_renderer
    import sprite_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sprite_wr_en,
    input  logic [sprite_idx_bits-1:0] sprite_wr_idx,
    input  sprite_attr_t               sprite_wr_attr,
    input  logic                       render_start,
    output logic                       renderer_busy,
    output logic [line_idx_bits-1:0]   renderer_rd_idx,
    input  pixel_t                     renderer_rd_data,
    output logic [line_idx_bits-1:0]   renderer_wr_idx,
    output pixel_t                     renderer_wr_data,
    output logic                       renderer_wr_en
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_draw
    } state_t;

    state_t                     state;
    logic [sprite_idx_bits-1:0] spr_idx;
    logic [sprite_idx_bits-1:0] table_rd_addr;
    sprite_attr_t               attr;
    logic                       last_sprite;
    logic                       last_sprite_q;
    logic                       attr_empty;
    logic [line_idx_bits:0]     span_end;
    logic [line_idx_bits-1:0]   span_last;
    logic [line_idx_bits-1:0]   cur_idx;
    logic [line_idx_bits-1:0]   end_idx;
    logic                       wr_pending;
    logic [line_idx_bits-1:0]   wr_idx_q;
    pixel_t                     color_q;

    dpram #(
        .addr_width (sprite_idx_bits),
        .data_t     (sprite_attr_t)
    ) u_sprite_table (
        .clk     (clk),
        .wr_addr (sprite_wr_idx),
        .wr_data (sprite_wr_attr),
        .wr_en   (sprite_wr_en),
        .rd_addr (table_rd_addr),
        .rd_data (attr)
    );

    // Fetch the next entry during setup so it is ready when this sprite ends
    assign table_rd_addr = (state == st_setup) ? spr_idx + 1'b1 : spr_idx;
    assign last_sprite   = (spr_idx == sprite_idx_bits'(sprite_count - 1));

    ////////////////////////////////////////
    // Run limits with clipping at 639
    ////////////////////////////////////////

    assign attr_empty = !attr.enable || (attr.width == '0) ||
                        (attr.x >= line_idx_bits'(line_width));
    assign span_end   = (line_idx_bits + 1)'(attr.x) + (line_idx_bits + 1)'(attr.width) - 1'b1;
    assign span_last  = (span_end >= (line_idx_bits + 1)'(line_width)) ?
                        line_idx_bits'(line_width - 1) : span_end[line_idx_bits-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= st_idle;
            spr_idx       <= '0;
            last_sprite_q <= 1'b0;
            cur_idx       <= '0;
            end_idx       <= '0;
            wr_pending    <= 1'b0;
        end else begin
            wr_pending <= (state == st_draw);
            case (state)
                st_idle: begin
                    if (render_start) begin
                        state <= st_setup;
                    end
                end
                // Also the gap cycle where the previous sprite's last write lands
                st_setup: begin
                    spr_idx       <= spr_idx + 1'b1;
                    last_sprite_q <= last_sprite;
                    cur_idx       <= attr.x;
                    end_idx       <= span_last;
                    if (!attr_empty) begin
                        state <= st_draw;
                    end else if (last_sprite) begin
                        state <= st_idle;
                    end
                end
                st_draw: begin
                    if (cur_idx == end_idx) begin
                        state <= last_sprite_q ? st_idle : st_setup;
                    end else begin
                        cur_idx <= cur_idx + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_setup) begin
            color_q <= attr.color;
        end
        wr_idx_q <= cur_idx;
    end

    assign renderer_rd_idx  = cur_idx;
    assign renderer_wr_idx  = wr_idx_q;
    assign renderer_wr_data = color_q;

    // Lower numbered sprites win, so paint only transparent pixels
    assign renderer_wr_en = wr_pending && (renderer_rd_data == '0);
    assign renderer_busy  = render_start || (state != st_idle) || wr_pending;

endmodule

// ==== test/tb_sprite_subsystem.sv ====
// Self-checking testbench for the sprite layer; random scenes against a line model and stream checker
module tb_sprite_subsystem
    import sprite_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int total_lines    = 11;
    localparam int timeout_cycles = 12 * 4000;

    logic                       clk;
    logic                       rst;
    logic                       line_start;
    logic                       sprite_wr_en;
    logic [sprite_idx_bits-1:0] sprite_wr_idx;
    sprite_attr_t               sprite_wr_attr;
    pixel_t                     pixel_data;
    logic                       pixel_valid;
    logic                       pixel_ready;
    logic                       busy;

    sprite_attr_t shadow_table [sprite_count];
    pixel_t       prev_line [line_width];
    pixel_t       expected_line [line_width];
    pixel_t       held_data;
    logic         hold_pending;
    logic         busy_q;
    logic [31:0]  scene_rng;
    logic [31:0]  ready_rng;
    int           pixel_count;
    int           pixel_total;
    int           lines_accepted;
    int           error_count;
    int           cycle_count;

    sprite_subsystem UUT (
        .clk            (clk),
        .rst            (rst),
        .line_start     (line_start),
        .sprite_wr_en   (sprite_wr_en),
        .sprite_wr_idx  (sprite_wr_idx),
        .sprite_wr_attr (sprite_wr_attr),
        .pixel_data     (pixel_data),
        .pixel_valid    (pixel_valid),
        .pixel_ready    (pixel_ready),
        .busy           (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic sprite_attr_t make_sprite(input logic en, input int x, input int w,
                                                 input pixel_t color);
        sprite_attr_t a;
        a.enable = en;
        a.x      = 10'(x);
        a.width  = 6'(w);
        a.color  = color;
        return a;
    endfunction

    ////////////////////////////////////////
    // Line model
    ////////////////////////////////////////

    // Paints sprites 0 to 7 over a cleared line, only into transparent pixels
    task automatic paint_line();
        int p;
        for (int i = 0; i < line_width; i++) begin
            prev_line[i] = '0;
        end
        for (int s = 0; s < sprite_count; s++) begin
            if (shadow_table[s].enable) begin
                for (int n = 0; n < int'(shadow_table[s].width); n++) begin
                    p = int'(shadow_table[s].x) + n;
                    if (p < line_width && prev_line[p] == '0) begin
                        prev_line[p] = shadow_table[s].color;
                    end
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic wait_idle();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic write_sprite(input int idx, input sprite_attr_t attr);
        @(posedge clk);
        sprite_wr_en   <= 1'b1;
        sprite_wr_idx  <= 3'(idx);
        sprite_wr_attr <= attr;
        shadow_table[idx] = attr;
        @(posedge clk);
        sprite_wr_en <= 1'b0;
    endtask

    task automatic pulse_line_start();
        @(posedge clk);
        line_start <= 1'b1;
        @(posedge clk);
        line_start <= 1'b0;
    endtask

    task automatic start_line();
        wait_idle();
        pulse_line_start();
    endtask

    // Extra start in the middle of a line, which the DUT has to drop
    task automatic pulse_while_busy();
        scene_rng = xorshift32(scene_rng);
        repeat (20 + int'(scene_rng[7:0])) @(posedge clk);
        pulse_line_start();
    endtask

    task automatic clear_table();
        wait_idle();
        for (int s = 0; s < sprite_count; s++) begin
            write_sprite(s, make_sprite(1'b0, 0, 0, '0));
        end
    endtask

    // Mostly enabled sprites, a quarter of them placed near the right edge
    task automatic random_scene();
        logic [31:0] r;
        int          x;
        wait_idle();
        for (int s = 0; s < sprite_count; s++) begin
            scene_rng = xorshift32(scene_rng);
            r = scene_rng;
            if (r[3:2] == 2'b00) begin
                x = 600 + int'(r[31:24]) % 40;
            end else begin
                x = int'(r[31:16]) % line_width;
            end
            scene_rng = xorshift32(scene_rng);
            write_sprite(s, make_sprite(r[1:0] != 2'b00, x, int'(r[9:4]), scene_rng[15:0]));
        end
    endtask

    always @(posedge clk) begin
        ready_rng = xorshift32(ready_rng);
        pixel_ready <= (ready_rng[9:8] != 2'b00);
    end

    ////////////////////////////////////////
    // Stream checker
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            // Start seen here is taken by the DUT on the next rising edge
            if (line_start && !busy) begin
                expected_line = prev_line;
                paint_line();
                pixel_count = 0;
                lines_accepted++;
            end
            if (hold_pending) begin
                assert (pixel_valid && pixel_data == held_data) else begin
                    error_count++;
                    $display("FAILED at %0t: stalled pixel changed, held %h now %h valid %b",
                             $time, held_data, pixel_data, pixel_valid);
                end
            end
            hold_pending = pixel_valid && !pixel_ready;
            held_data    = pixel_data;
            if (pixel_valid && pixel_ready) begin
                assert (pixel_count < line_width) else begin
                    error_count++;
                    $display("Pixel sent beyond the end of the line at %0t", $time);
                end
                if (pixel_count < line_width) begin
                    assert (pixel_data == expected_line[pixel_count]) else begin
                        error_count++;
                        $display("FAILED at %0t: pixel %0d expected %h received %h",
                                 $time, pixel_count, expected_line[pixel_count], pixel_data);
                    end
                end
                pixel_count++;
                pixel_total++;
            end
            if (busy_q && !busy) begin
                assert (pixel_count == line_width) else begin
                    error_count++;
                    $display("Line ended after %0d pixels instead of %0d at %0t",
                             pixel_count, line_width, $time);
                end
            end
            busy_q = busy;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("Errors: %0d, lines: %0d, pixels: %0d",
                     error_count + 1, lines_accepted, pixel_total);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        rst            = 1'b1;
        line_start     = 1'b0;
        sprite_wr_en   = 1'b0;
        sprite_wr_idx  = '0;
        sprite_wr_attr = '0;
        pixel_ready    = 1'b0;
        hold_pending   = 1'b0;
        busy_q         = 1'b0;
        scene_rng      = 32'd43;
        ready_rng      = 32'd43;
        pixel_count    = 0;
        pixel_total    = 0;
        lines_accepted = 0;
        error_count    = 0;
        cycle_count    = 0;
        for (int s = 0; s < sprite_count; s++) begin
            shadow_table[s] = '0;
        end
        // Lines before the first start are blank
        paint_line();
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        assert (!pixel_valid && !busy) else begin
            error_count++;
            $display("pixel_valid or busy high after reset at %0t", $time);
        end

        // Empty table, then one plain sprite, then one clipped at the right edge
        start_line();
        wait_idle();
        write_sprite(3, make_sprite(1'b1, 100, 20, 16'h1234));
        start_line();
        wait_idle();
        write_sprite(3, make_sprite(1'b0, 0, 0, '0));
        write_sprite(5, make_sprite(1'b1, 630, 30, 16'h0f0f));
        start_line();
        pulse_while_busy();

        // Overlap, a disabled sprite and a zero-width sprite
        clear_table();
        write_sprite(0, make_sprite(1'b1, 200, 40, 16'haaaa));
        write_sprite(1, make_sprite(1'b1, 220, 40, 16'h5555));
        write_sprite(2, make_sprite(1'b0, 300, 20, 16'hc0c0));
        write_sprite(4, make_sprite(1'b1, 400, 0, 16'hdddd));
        start_line();

        for (int n = 0; n < 5; n++) begin
            random_scene();
            start_line();
            pulse_while_busy();
        end

        // Removed scene, then one more line to see the blank result
        clear_table();
        start_line();
        start_line();
        wait_idle();
        // Let the stream checker see the falling busy of the last line
        @(posedge clk);

        assert (lines_accepted == total_lines) else begin
            error_count++;
            $display("Accepted %0d lines instead of %0d", lines_accepted, total_lines);
        end
        $display("Errors: %0d, lines: %0d, pixels: %0d", error_count, lines_accepted, pixel_total);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
